//--- common/degu_defines.svh
// degu fabric constants
`ifndef DEGU_DEFINES_SVH
`define DEGU_DEFINES_SVH

// data path
// word width, address width too
`define DEGU_XLEN 32
// bytes per word
`define DEGU_BLEN 4

// address map
// 16 KiB of data memory, byte addressed
`define DEGU_MEM_ADR_W 14
// set for peripherals, clear for memory
`define DEGU_PER_SEL_BIT 14

// GPIO
`define DEGU_GPIO_W 32
// register offsets inside the peripheral window
`define DEGU_GPIO_OUT 6'h00
`define DEGU_GPIO_ENA 6'h04
`define DEGU_GPIO_INP 6'h08
// offsets 0x40-0x7f were the UART window
`define DEGU_GPIO_ERR_BIT 6

`endif

//--- common/degu_bus_pkg.sv
// degu bus types
`include "degu_defines.svh"

package degu_bus_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // basic data types
  ////////////////////////////////////////////////////////////////////////////

  // one data word
  typedef logic [`DEGU_XLEN-1:0] word_t;

  // one strobe per byte lane
  typedef logic [`DEGU_BLEN-1:0] ben_t;

  // word index into the data memory
  typedef logic [`DEGU_MEM_ADR_W-$clog2(`DEGU_BLEN)-1:0] mem_idx_t;

  // log2 of transfer size in bytes
  // 0 byte, 1 halfword, 2 word
  typedef logic [1:0] bus_size_t;

  ////////////////////////////////////////////////////////////////////////////
  // bus payloads
  ////////////////////////////////////////////////////////////////////////////

  // size-coded request from the load/store master
  typedef struct packed {
    logic                  wen;  // write enable
    logic [`DEGU_XLEN-1:0] adr;  // byte address
    bus_size_t             siz;  // transfer size
    word_t                 wdt;  // write data, low bytes valid
  } bus_req_t;

  // response, one cycle after request
  typedef struct packed {
    word_t rdt;  // read data
    logic  err;  // error flag
  } bus_rsp_t;

  // byte-enable request toward the RAM
  typedef struct packed {
    logic     wen;  // write enable
    mem_idx_t idx;  // word index
    ben_t     ben;  // byte enables
    word_t    wdt;  // write data on its lanes
  } mem_req_t;

endpackage

//--- hdl/bus_demultiplexer.sv
// memory/peripheral bus demultiplexer
`timescale 1ns/1ps
`include "degu_defines.svh"

module bus_demultiplexer (
  // system
  input  logic                   clk,
  input  logic                   reset,
  // from the load/store master
  input  logic                   req_vld,
  input  degu_bus_pkg::bus_req_t req,
  // toward the data memory
  output logic                   mem_vld,
  output degu_bus_pkg::bus_req_t mem_req,
  // toward the peripherals
  output logic                   per_vld,
  output degu_bus_pkg::bus_req_t per_req,
  // returning responses
  input  degu_bus_pkg::word_t    mem_rdt,
  input  degu_bus_pkg::bus_rsp_t per_rsp,
  // merged response
  output logic                   rsp_vld,
  output degu_bus_pkg::bus_rsp_t rsp
);

  import degu_bus_pkg::*;

  // region select, 1 for peripherals
  logic     sel;
  // select of the request in flight
  logic     sel_q;
  // memory side as a full response
  bus_rsp_t mem_rsp;

  ////////////////////////////////////////////////////////////////////////////
  // request path
  ////////////////////////////////////////////////////////////////////////////

  // only one address bit decoded
  // upper bits alias
  assign sel = req.adr[`DEGU_PER_SEL_BIT];

  // valid steered to one side only
  assign mem_vld = req_vld & ~sel;
  assign per_vld = req_vld &  sel;

  // payload goes to both sides
  assign mem_req = req;
  assign per_req = req;

  ////////////////////////////////////////////////////////////////////////////
  // response path
  ////////////////////////////////////////////////////////////////////////////

  // every target answers after one cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      rsp_vld <= 1'b0;
      sel_q   <= 1'b0;
    end else begin
      rsp_vld <= req_vld;
      // hold the last select between requests
      if (req_vld) begin
        sel_q <= sel;
      end
    end
  end

  // memory never errors
  assign mem_rsp.rdt = mem_rdt;
  assign mem_rsp.err = 1'b0;

  // merge by the remembered region
  assign rsp = sel_q ? per_rsp : mem_rsp;

endmodule

//--- hdl/logsize_to_byteena.sv
// size to byte-enable converter
`timescale 1ns/1ps
`include "degu_defines.svh"

module logsize_to_byteena (
  // system
  input  logic                   clk,
  input  logic                   reset,
  // size-coded side
  input  logic                   sub_vld,
  input  degu_bus_pkg::bus_req_t sub_req,
  output degu_bus_pkg::word_t    sub_rdt,
  // byte-enable side
  output logic                   ram_vld,
  output degu_bus_pkg::mem_req_t ram_req,
  input  degu_bus_pkg::word_t    ram_rdt
);

  import degu_bus_pkg::*;

  localparam int unsigned BLOG = $clog2(`DEGU_BLEN);

  // byte offset inside the word
  logic [BLOG-1:0] off;
  // offset of the outstanding read
  logic [BLOG-1:0] off_q;
  // source lane mask for write replication
  logic [BLOG-1:0] lane_msk;

  // lanes covered by a transfer at offset 0
  function automatic ben_t size_mask(input bus_size_t siz);
    ben_t mask;
    for (int i = 0; i < `DEGU_BLEN; i++) begin
      mask[i] = (i < (1 << siz));
    end
    return mask;
  endfunction

  assign off      = sub_req.adr[BLOG-1:0];
  assign lane_msk = BLOG'((1 << sub_req.siz) - 1);

  // request conversion, no delay
  assign ram_vld     = sub_vld;
  assign ram_req.wen = sub_req.wen;
  assign ram_req.idx = sub_req.adr[`DEGU_MEM_ADR_W-1:BLOG];
  assign ram_req.ben = size_mask(sub_req.siz) << off;

  // low bytes copied onto every lane
  // so the enabled lanes see the right byte
  always_comb begin
    for (int i = 0; i < `DEGU_BLEN; i++) begin
      ram_req.wdt[8*i +: 8] = sub_req.wdt[8*(i & lane_msk) +: 8];
    end
  end

  // remember offset for the read data
  always_ff @(posedge clk) begin
    if (reset) begin
      off_q <= '0;
    end else if (sub_vld) begin
      off_q <= off;
    end
  end

  // addressed bytes down to bit 0
  assign sub_rdt = ram_rdt >> {off_q, 3'b000};

endmodule

//--- hdl/request_register.sv
// peripheral request register
`timescale 1ns/1ps

module request_register (
  // system
  input  logic                   clk,
  input  logic                   reset,
  // from the demultiplexer
  input  logic                   sub_vld,
  input  degu_bus_pkg::bus_req_t sub_req,
  // toward the zero-delay peripheral
  output logic                   man_vld,
  output degu_bus_pkg::bus_req_t man_req
);

  import degu_bus_pkg::*;

  // registered valid
  logic     vld_q;
  // registered payload
  bus_req_t req_q;

  // valid flag is control
  always_ff @(posedge clk) begin
    if (reset) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= sub_vld;
    end
  end

  // payload only loaded with a request
  always_ff @(posedge clk) begin
    if (sub_vld) begin
      req_q <= sub_req;
    end
  end

  // peripheral sees the request a cycle late
  // its same-cycle answer lands in the bus response slot
  assign man_vld = vld_q;
  assign man_req = req_q;

endmodule

//--- memory/data_memory.sv
// data memory
`timescale 1ns/1ps
`include "degu_defines.svh"

module data_memory (
  // system
  input  logic                   clk,
  // byte-enable request
  input  logic                   ram_vld,
  input  degu_bus_pkg::mem_req_t ram_req,
  // read data, one cycle later
  output degu_bus_pkg::word_t    ram_rdt
);

  import degu_bus_pkg::*;

  // words in the array
  localparam int unsigned DEPTH = 2**(`DEGU_MEM_ADR_W - $clog2(`DEGU_BLEN));

  // storage, contents undefined after reset
  word_t mem [0:DEPTH-1];

  ////////////////////////////////////////////////////////////////////////////
  // write port
  ////////////////////////////////////////////////////////////////////////////

  // per-byte strobes
  always_ff @(posedge clk) begin
    if (ram_vld && ram_req.wen) begin
      for (int i = 0; i < `DEGU_BLEN; i++) begin
        if (ram_req.ben[i]) begin
          mem[ram_req.idx][8*i +: 8] <= ram_req.wdt[8*i +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read port
  ////////////////////////////////////////////////////////////////////////////

  // registered read, old data on a write
  // output holds between accesses
  always_ff @(posedge clk) begin
    if (ram_vld) begin
      ram_rdt <= mem[ram_req.idx];
    end
  end

endmodule

//--- gpio/gpio_controller.sv
// GPIO controller
`timescale 1ns/1ps
`include "degu_defines.svh"

module gpio_controller (
  // system
  input  logic                         clk,
  input  logic                         reset,
  // zero-delay bus
  input  logic                         tcb_vld,
  input  degu_bus_pkg::bus_req_t       tcb_req,
  output degu_bus_pkg::bus_rsp_t       tcb_rsp,
  // pins
  output logic [`DEGU_GPIO_W-1:0]      gpio_o,
  output logic [`DEGU_GPIO_W-1:0]      gpio_e,
  input  logic [`DEGU_GPIO_W-1:0]      gpio_i
);

  import degu_bus_pkg::*;

  localparam int unsigned OFF_W = `DEGU_GPIO_ERR_BIT;

  // register offset
  logic [OFF_W-1:0]          off;
  // access into the old UART window
  logic                      err;
  // write strobe
  logic                      wen;
  // input synchronizer stages
  logic [`DEGU_GPIO_W-1:0]   gpio_s0;
  logic [`DEGU_GPIO_W-1:0]   gpio_s1;
  // read-back mux
  word_t                     rdt;

  ////////////////////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////////////////////

  assign off = tcb_req.adr[OFF_W-1:0];
  assign err = tcb_req.adr[`DEGU_GPIO_ERR_BIT];
  // size ignored, full word written
  assign wen = tcb_vld & tcb_req.wen & ~err;

  ////////////////////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////////////////////

  // output and enable
  always_ff @(posedge clk) begin
    if (reset) begin
      gpio_o <= '0;
      gpio_e <= '0;
    end else if (wen) begin
      if (off == `DEGU_GPIO_OUT) gpio_o <= tcb_req.wdt[`DEGU_GPIO_W-1:0];
      if (off == `DEGU_GPIO_ENA) gpio_e <= tcb_req.wdt[`DEGU_GPIO_W-1:0];
    end
  end

  // two flops against metastability
  always_ff @(posedge clk) begin
    gpio_s0 <= gpio_i;
    gpio_s1 <= gpio_s0;
  end

  ////////////////////////////////////////////////////////////////////////////
  // response
  ////////////////////////////////////////////////////////////////////////////

  // unmapped offsets read as zero
  always_comb begin
    rdt = '0;
    case (off)
      `DEGU_GPIO_OUT: rdt[`DEGU_GPIO_W-1:0] = gpio_o;
      `DEGU_GPIO_ENA: rdt[`DEGU_GPIO_W-1:0] = gpio_e;
      `DEGU_GPIO_INP: rdt[`DEGU_GPIO_W-1:0] = gpio_s1;
      default:        rdt = '0;
    endcase
  end

  // answered in the request cycle
  assign tcb_rsp.rdt = rdt;
  assign tcb_rsp.err = err;

endmodule

//--- hdl/degu_lsu_fabric_top.sv
// degu load/store fabric
`timescale 1ns/1ps
`include "degu_defines.svh"

module degu_lsu_fabric_top (
  // system
  input  logic                    clk,
  input  logic                    reset,
  // load/store master
  input  logic                    req_vld,
  input  degu_bus_pkg::bus_req_t  req,
  output logic                    rsp_vld,
  output degu_bus_pkg::bus_rsp_t  rsp,
  // GPIO pins
  output logic [`DEGU_GPIO_W-1:0] gpio_o,
  output logic [`DEGU_GPIO_W-1:0] gpio_e,
  input  logic [`DEGU_GPIO_W-1:0] gpio_i
);

  ////////////////////////////////////////////////////////////////////////////
  // local buses
  ////////////////////////////////////////////////////////////////////////////

  // memory branch, size coded
  logic                   mem_vld;
  degu_bus_pkg::bus_req_t mem_req;
  degu_bus_pkg::word_t    mem_rdt;
  // memory branch, byte enables
  logic                   ram_vld;
  degu_bus_pkg::mem_req_t ram_req;
  degu_bus_pkg::word_t    ram_rdt;
  // peripheral branch, before and after the register
  logic                   per_vld;
  degu_bus_pkg::bus_req_t per_req;
  logic                   gpio_vld;
  degu_bus_pkg::bus_req_t gpio_req;
  degu_bus_pkg::bus_rsp_t gpio_rsp;

  ////////////////////////////////////////////////////////////////////////////
  // instances
  ////////////////////////////////////////////////////////////////////////////

  // split on the region bit
  bus_demultiplexer i_demux (
    .clk     (clk),      .reset   (reset),
    .req_vld (req_vld),  .req     (req),
    .mem_vld (mem_vld),  .mem_req (mem_req),
    .per_vld (per_vld),  .per_req (per_req),
    .mem_rdt (mem_rdt),  .per_rsp (gpio_rsp),
    .rsp_vld (rsp_vld),  .rsp     (rsp)
  );

  // size to byte enables
  logsize_to_byteena i_l2b (
    .clk     (clk),      .reset   (reset),
    .sub_vld (mem_vld),  .sub_req (mem_req),  .sub_rdt (mem_rdt),
    .ram_vld (ram_vld),  .ram_req (ram_req),  .ram_rdt (ram_rdt)
  );

  data_memory i_dmem (
    .clk     (clk),
    .ram_vld (ram_vld),  .ram_req (ram_req),  .ram_rdt (ram_rdt)
  );

  // one-cycle request delay
  request_register i_preg (
    .clk     (clk),       .reset   (reset),
    .sub_vld (per_vld),   .sub_req (per_req),
    .man_vld (gpio_vld),  .man_req (gpio_req)
  );

  gpio_controller i_gpio (
    .clk     (clk),       .reset   (reset),
    .tcb_vld (gpio_vld),  .tcb_req (gpio_req),  .tcb_rsp (gpio_rsp),
    .gpio_o  (gpio_o),    .gpio_e  (gpio_e),    .gpio_i  (gpio_i)
  );

endmodule

//--- verif/tb_degu_fabric.sv
// degu fabric testbench
`timescale 1ns/1ps
`include "degu_defines.svh"

module tb_degu_fabric;

  import degu_bus_pkg::*;

  // loop counts per test
  localparam int unsigned N_MEM  = 16;
  localparam int unsigned N_SUB  = 16;
  localparam int unsigned N_GPIO = 4;
  // cycles of all tests, then a margin
  localparam int unsigned RUN_CYC = 17 + 2*N_MEM + 12*N_SUB + 24*N_GPIO;
  localparam int unsigned WD_NS   = (RUN_CYC + 100) * 20;
  // peripheral window base
  localparam logic [31:0] PER_BASE = 32'h1 << `DEGU_PER_SEL_BIT;

  logic                    clk = 1'b0;
  logic                    reset;
  logic                    req_vld;
  bus_req_t                req;
  logic                    rsp_vld;
  bus_rsp_t                rsp;
  logic [`DEGU_GPIO_W-1:0] gpio_o;
  logic [`DEGU_GPIO_W-1:0] gpio_e;
  logic [`DEGU_GPIO_W-1:0] gpio_i;

  // byte mirror of the data memory
  logic [7:0] model [0:(1<<`DEGU_MEM_ADR_W)-1];
  // expected gpio registers
  word_t      out_m;
  word_t      ena_m;
  integer     seed = 32'hb402_3770;
  int         errors = 0;
  int         checks = 0;
  int         tests = 0;

  degu_lsu_fabric_top i_dut (
    .clk     (clk),     .reset   (reset),
    .req_vld (req_vld), .req     (req),
    .rsp_vld (rsp_vld), .rsp     (rsp),
    .gpio_o  (gpio_o),  .gpio_e  (gpio_e),  .gpio_i (gpio_i)
  );

  always #10 clk = ~clk;

  // one response per request, one cycle later, back to back too
  rsp_follows_req: assert property (
    @(posedge clk) disable iff (reset) rsp_vld == $past(req_vld))
  else begin
    $display("ERROR %0t: rsp_vld does not follow req_vld", $time);
    errors++;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input word_t got, input word_t exp);
    checks++;
    assert (got === exp)
    else begin
      $display("ERROR %0t: %0s is %08h, expected %08h", $time, what, got, exp);
      errors++;
    end
  endtask

  // aligned word from the mirror
  function automatic word_t model_word(input logic [31:0] adr);
    logic [13:0] a;
    a = {adr[13:2], 2'b00};
    return {model[a | 14'd3], model[a | 14'd2], model[a | 14'd1], model[a]};
  endfunction

  // low 2^siz bytes from the mirror, upper bytes zero
  function automatic word_t model_read(input logic [31:0] adr, input bus_size_t siz);
    logic [13:0] a;
    word_t       w;
    a = adr[13:0];
    w = '0;
    for (int i = 0; i < (1 << siz); i++) begin
      w[8*i +: 8] = model[a + 14'(i)];
    end
    return w;
  endfunction

  // low 2^siz bytes land at the address, upper bits alias
  task automatic model_write(input logic [31:0] adr, input bus_size_t siz, input word_t wdt);
    logic [13:0] a;
    a = adr[13:0];
    for (int i = 0; i < (1 << siz); i++) begin
      model[a + 14'(i)] = wdt[8*i +: 8];
    end
  endtask

  // request on the next edge, held for one cycle by the caller
  task automatic drive(input logic wen, input logic [31:0] adr, input bus_size_t siz,
                       input word_t wdt);
    bus_req_t r;
    r.wen = wen;
    r.adr = adr;
    r.siz = siz;
    r.wdt = wdt;
    @(posedge clk);
    req_vld <= 1'b1;
    req     <= r;
  endtask

  task automatic idle();
    @(posedge clk);
    req_vld <= 1'b0;
  endtask

  // single access, response taken mid-cycle
  task automatic access(input logic wen, input logic [31:0] adr, input bus_size_t siz,
                        input word_t wdt, output word_t rdt, output logic err);
    drive(wen, adr, siz, wdt);
    idle();
    @(negedge clk);
    rdt = rsp.rdt;
    err = rsp.err;
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("%0s finished, %0d errors so far", name, errors);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    word_t       rnd;
    word_t       got;
    logic        err;
    logic [31:0] adr;
    bus_size_t   siz;
    word_t       msk;
    logic [31:0] adrs [N_MEM];
    reset   <= 1'b1;
    req_vld <= 1'b0;
    req     <= '0;
    gpio_i  <= '0;

    // outputs quiet through reset and just after
    repeat (15) begin
      @(negedge clk);
      check_value("rsp_vld in reset", {31'b0, rsp_vld}, '0);
      check_value("gpio_o in reset", gpio_o, '0);
      check_value("gpio_e in reset", gpio_e, '0);
    end
    @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_value("rsp_vld after reset", {31'b0, rsp_vld}, '0);
    check_value("gpio_o after reset", gpio_o, '0);
    check_value("gpio_e after reset", gpio_e, '0);
    finish_test("reset");

    // back-to-back word writes straight into back-to-back reads
    for (int i = 0; i < N_MEM; i++) begin
      rnd = $random(seed);
      adrs[i] = rnd & 32'hffff_bffc;
      rnd = $random(seed);
      drive(1'b1, adrs[i], 2'd2, rnd);
      model_write(adrs[i], 2'd2, rnd);
    end
    for (int i = 0; i <= N_MEM; i++) begin
      if (i < N_MEM) begin
        drive(1'b0, adrs[i], 2'd2, '0);
      end else begin
        idle();
      end
      // response of the previous read
      if (i > 0) begin
        @(negedge clk);
        check_value("word read", rsp.rdt, model_word(adrs[i-1]));
        check_value("word read err", {31'b0, rsp.err}, '0);
      end
    end
    finish_test("memory words");

    for (int i = 0; i < N_SUB; i++) begin
      rnd = $random(seed);
      siz = {1'b0, rnd[31]};
      adr = rnd & ((siz == 2'd1) ? 32'hffff_bffe : 32'hffff_bfff);
      // full word first, so the merge shows
      rnd = $random(seed);
      access(1'b1, adr & ~32'h3, 2'd2, rnd, got, err);
      model_write(adr & ~32'h3, 2'd2, rnd);
      rnd = $random(seed);
      access(1'b1, adr, siz, rnd, got, err);
      model_write(adr, siz, rnd);
      access(1'b0, adr & ~32'h3, 2'd2, '0, got, err);
      check_value("merged word", got, model_word(adr));
      // only the addressed bytes are defined
      access(1'b0, adr, siz, '0, got, err);
      msk = (siz == 2'd1) ? 32'h0000_ffff : 32'h0000_00ff;
      check_value("sub-word read", got & msk, model_read(adr, siz));
    end
    finish_test("sub-word access");

    for (int i = 0; i < N_GPIO; i++) begin
      out_m = $random(seed);
      ena_m = $random(seed);
      access(1'b1, PER_BASE + 32'(`DEGU_GPIO_OUT), 2'd2, out_m, got, err);
      // pins follow one cycle after the response
      @(negedge clk);
      check_value("gpio_o", gpio_o, out_m);
      access(1'b1, PER_BASE + 32'(`DEGU_GPIO_ENA), 2'd2, ena_m, got, err);
      @(negedge clk);
      check_value("gpio_e", gpio_e, ena_m);
      access(1'b0, PER_BASE + 32'(`DEGU_GPIO_OUT), 2'd2, '0, got, err);
      check_value("gpio_o read-back", got, out_m);
      access(1'b0, PER_BASE + 32'(`DEGU_GPIO_ENA), 2'd2, '0, got, err);
      check_value("gpio_e read-back", got, ena_m);
      check_value("gpio read err", {31'b0, err}, '0);
    end
    finish_test("gpio outputs");

    for (int i = 0; i < N_GPIO; i++) begin
      rnd = $random(seed);
      @(posedge clk);
      gpio_i <= rnd;
      // two synchronizer flops and a spare cycle
      repeat (3) @(posedge clk);
      access(1'b0, PER_BASE + 32'(`DEGU_GPIO_INP), 2'd2, '0, got, err);
      check_value("gpio input", got, rnd);
    end
    finish_test("gpio inputs");

    // old uart window, 0x40 to 0x7f
    for (int i = 0; i < N_GPIO; i++) begin
      rnd = $random(seed);
      // first writes alias onto the out and enable offsets
      if (i < 2) begin
        adr = PER_BASE + 32'h40 + 32'(4*i);
      end else begin
        adr = PER_BASE + 32'h40 + (rnd & 32'h3c);
      end
      access(i < 2, adr, 2'd2, (i == 0) ? ~out_m : ~ena_m, got, err);
      check_value("uart window err", {31'b0, err}, 32'd1);
      @(negedge clk);
      check_value("gpio_o after uart access", gpio_o, out_m);
      check_value("gpio_e after uart access", gpio_e, ena_m);
    end
    finish_test("uart window");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // hang guard
  initial begin
    #(WD_NS);
    $display("watchdog expired after %0d ns, the tests did not finish", WD_NS);
    $display("Testbench failed");
    $finish;
  end

endmodule

//--- compile.f
+incdir+common
common/degu_bus_pkg.sv
hdl/bus_demultiplexer.sv
hdl/logsize_to_byteena.sv
hdl/request_register.sv
memory/data_memory.sv
gpio/gpio_controller.sv
hdl/degu_lsu_fabric_top.sv
verif/tb_degu_fabric.sv

//--- Makefile
# Verilator flow for the degu load/store fabric

TOP := tb_degu_fabric

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module degu_lsu_fabric_top -f compile.f
	verilator --lint-only --timing --assert --top-module $(TOP) -f compile.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
